/* sources.f */
source/lane_pkg.sv
source/lane_fifo.sv
source/operand_queue.sv
source/lane_valu.sv
source/lane_operand_path.sv
+incdir+tb
tb/tb_lane.sv

/* Makefile */
# Verilator build and run of the lane operand path testbench
# Override on the command line, e.g. make run SEED=12345

VERILATOR ?= verilator
TOP       ?= tb_lane
SEED      ?= 90392898
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_lane_model.svh */
/* Reference model of the operand path, independent of the RTL code.
   Included inside the testbench module after the lane_pkg import */
`ifndef TB_LANE_MODEL_SVH
`define TB_LANE_MODEL_SVH
`default_nettype none

  // Bytes in one element of the given width
  function automatic int ew_bytes(vew_e vew);
    return 1 << int'(vew);
  endfunction

  // Widening factor of a conversion, 1 when none
  function automatic int conv_factor(opq_conv_e conv);
    case (conv)
      OpqConvSExt2, OpqConvZExt2: return 2;
      OpqConvSExt4, OpqConvZExt4: return 4;
      OpqConvSExt8, OpqConvZExt8: return 8;
      default:                    return 1;
    endcase
  endfunction

  function automatic logic conv_is_signed(opq_conv_e conv);
    return (conv == OpqConvSExt2) || (conv == OpqConvSExt4) || (conv == OpqConvSExt8);
  endfunction

  // Source words per operand, vl times source bytes over 8 rounded up
  function automatic int input_words(vlen_t vl, vew_e vew, opq_conv_e conv);
    int src_bytes;
    src_bytes = ew_bytes(vew) / conv_factor(conv);
    return (int'(vl) * src_bytes + 7) / 8;
  endfunction

  // Result words of one instruction
  function automatic int result_words(vlen_t vl, vew_e vew);
    return (int'(vl) * ew_bytes(vew) + 7) / 8;
  endfunction

  // Mask covering the low bits of one element
  function automatic logic [63:0] low_mask(int bits);
    if (bits >= 64) begin
      return '1;
    end
    return (64'd1 << bits) - 64'd1;
  endfunction

  // Widened word taken from one slot of a source word
  function automatic elen_t widen_word(elen_t src, int slot, vew_e vew, opq_conv_e conv);
    int          dbits;
    int          sbits;
    int          n;
    logic [63:0] elem;
    elen_t       res;
    dbits = 8 * ew_bytes(vew);
    sbits = dbits / conv_factor(conv);
    n     = 64 / dbits;
    res   = '0;
    for (int e = 0; e < n; e++) begin
      // Source elements of a slot sit next to each other
      elem = (src >> ((slot * n + e) * sbits)) & low_mask(sbits);
      if (conv_is_signed(conv) && sbits < 64 && elem[sbits-1]) begin
        elem = elem | ~low_mask(sbits);
      end
      res = res | ((elem & low_mask(dbits)) << (e * dbits));
    end
    return res;
  endfunction

  // Element by element result, no carry crosses an element
  function automatic elen_t combine_words(elen_t a, elen_t b, valu_op_e op, vew_e vew);
    int          dbits;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] er;
    elen_t       res;
    dbits = 8 * ew_bytes(vew);
    res   = '0;
    for (int e = 0; e < 64 / dbits; e++) begin
      ea = (a >> (e * dbits)) & low_mask(dbits);
      eb = (b >> (e * dbits)) & low_mask(dbits);
      case (op)
        ValuAdd: er = ea + eb;
        ValuSub: er = ea - eb;
        ValuAnd: er = ea & eb;
        default: er = ea ^ eb;
      endcase
      res = res | ((er & low_mask(dbits)) << (e * dbits));
    end
    return res;
  endfunction

`default_nettype wire
`endif

/* tb/tb_lane.sv */
/* Random instructions checked against a model; the register file is emulated
   with credits. Seed may be overridden as an elaboration parameter */
`timescale 1ns/10ps
`default_nettype none

module tb_lane import lane_pkg::*; #(
  parameter logic [31:0] Seed = 32'h05634942
);

  `include "tb_lane_model.svh"

  localparam int unsigned BufferDepth = 2;
  localparam int unsigned CmdDepth    = 2;
  localparam int          NumInstr    = 40;

  logic        clk_i;
  logic        rst_ni;
  lane_instr_t instr_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  elen_t       opa_i;
  logic        opa_valid_i;
  logic        opa_issued_i;
  logic        opa_ready_o;
  elen_t       opb_i;
  logic        opb_valid_i;
  logic        opb_issued_i;
  logic        opb_ready_o;
  elen_t       result_o;
  logic        result_valid_o;
  logic        result_last_o;
  logic        result_ready_i;

  // Whole stimulus and expected stream, built before reset
  lane_instr_t instr_list[$];
  elen_t       src_a[$];
  elen_t       src_b[$];
  elen_t       exp_word[$];
  logic        exp_last[$];
  logic        exp_pop_a[$];
  logic        exp_pop_b[$];
  // Delivery cycles of issued words, strictly increasing
  int          due_a[$];
  int          due_b[$];

  logic [31:0] rng_state;
  int          word_errs;
  int          flag_errs;
  int          other_errs;

  lane_operand_path #(
    .BufferDepth(BufferDepth),
    .CmdDepth   (CmdDepth)
  ) lane_operand_path_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Factor never above what the destination width allows
  function automatic opq_conv_e pick_conv(vew_e vew);
    logic [31:0] r;
    int          k;
    r = next_rand();
    k = int'(r[7:0]) % (int'(vew) + 1);
    case (k)
      1:       return r[8] ? OpqConvSExt2 : OpqConvZExt2;
      2:       return r[8] ? OpqConvSExt4 : OpqConvZExt4;
      3:       return r[8] ? OpqConvSExt8 : OpqConvZExt8;
      default: return OpqConvNone;
    endcase
  endfunction

  task automatic check_word(string name, elen_t got, elen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      word_errs++;
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      flag_errs++;
    end
  endtask

  task automatic build_stimulus();
    lane_instr_t ins;
    int          base_a;
    int          base_b;
    int          fa;
    int          fb;
    int          nr;
    elen_t       wa;
    elen_t       wb;
    for (int i = 0; i < NumInstr; i++) begin
      ins.op     = valu_op_e'(2'(next_rand()));
      ins.vew    = vew_e'(2'(next_rand()));
      ins.vl     = vlen_t'(1 + next_rand() % 40);
      ins.conv_a = pick_conv(ins.vew);
      ins.conv_b = pick_conv(ins.vew);
      instr_list.push_back(ins);
      base_a = src_a.size();
      base_b = src_b.size();
      for (int k = 0; k < input_words(ins.vl, ins.vew, ins.conv_a); k++) begin
        src_a.push_back({next_rand(), next_rand()});
      end
      for (int k = 0; k < input_words(ins.vl, ins.vew, ins.conv_b); k++) begin
        src_b.push_back({next_rand(), next_rand()});
      end
      fa = conv_factor(ins.conv_a);
      fb = conv_factor(ins.conv_b);
      nr = result_words(ins.vl, ins.vew);
      // Output word j uses slot j mod factor of source word j div factor
      for (int j = 0; j < nr; j++) begin
        wa = widen_word(src_a[base_a + j / fa], j % fa, ins.vew, ins.conv_a);
        wb = widen_word(src_b[base_b + j / fb], j % fb, ins.vew, ins.conv_b);
        exp_word.push_back(combine_words(wa, wb, ins.op, ins.vew));
        exp_last.push_back(j == nr - 1);
        exp_pop_a.push_back((j % fa == fa - 1) || (j == nr - 1));
        exp_pop_b.push_back((j % fb == fb - 1) || (j == nr - 1));
      end
    end
  endtask

  initial begin : main
    int   cycle;
    int   limit;
    int   instr_idx;
    int   issued_a;
    int   issued_b;
    int   sent_a;
    int   sent_b;
    int   out_a;
    int   out_b;
    int   last_due_a;
    int   last_due_b;
    int   stall;
    int   checked;
    int   delay;
    int   pending;
    logic last_exp;
    logic timed_out;
    rng_state  = Seed;
    word_errs  = 0;
    flag_errs  = 0;
    other_errs = 0;
    {cycle, instr_idx, issued_a, issued_b, sent_a, sent_b} = '0;
    {out_a, out_b, last_due_a, last_due_b, stall, checked} = '0;
    pending        = 0;
    timed_out      = 1'b0;
    rst_ni         = 1'b0;
    instr_i        = '0;
    instr_valid_i  = 1'b0;
    opa_i          = '0;
    opa_valid_i    = 1'b0;
    opa_issued_i   = 1'b0;
    opb_i          = '0;
    opb_valid_i    = 1'b0;
    opb_issued_i   = 1'b0;
    result_ready_i = 1'b0;
    build_stimulus();
    limit = 64 * (src_a.size() + src_b.size() + exp_word.size()) + 1000;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_last("result_valid_o", result_valid_o, 1'b0);
    check_last("instr_ready_o", instr_ready_o, 1'b1);
    while (exp_word.size() > 0 && !timed_out) begin
      @(negedge clk_i);
      cycle++;
      opa_valid_i  = 1'b0;
      opb_valid_i  = 1'b0;
      opa_issued_i = 1'b0;
      opb_issued_i = 1'b0;
      // Ready levels follow the outstanding issue counts
      check_last("opa_ready_o", opa_ready_o, out_a < BufferDepth);
      check_last("opb_ready_o", opb_ready_o, out_b < BufferDepth);
      // Command FIFOs hold every accepted instruction until its last word
      check_last("instr_ready_o", instr_ready_o, pending < CmdDepth);
      if (due_a.size() > 0 && due_a[0] == cycle) begin
        void'(due_a.pop_front());
        opa_i       = src_a[sent_a];
        opa_valid_i = 1'b1;
        sent_a++;
      end
      if (due_b.size() > 0 && due_b[0] == cycle) begin
        void'(due_b.pop_front());
        opb_i       = src_b[sent_b];
        opb_valid_i = 1'b1;
        sent_b++;
      end
      // Issue with a credit, deliver 1 to 3 cycles later and in order
      if (issued_a < src_a.size() && opa_ready_o && next_rand() % 4 != 0) begin
        opa_issued_i = 1'b1;
        issued_a++;
        out_a++;
        delay      = int'(1 + next_rand() % 3);
        last_due_a = (cycle + delay > last_due_a) ? cycle + delay : last_due_a + 1;
        due_a.push_back(last_due_a);
      end
      if (issued_b < src_b.size() && opb_ready_o && next_rand() % 4 != 0) begin
        opb_issued_i = 1'b1;
        issued_b++;
        out_b++;
        delay      = int'(1 + next_rand() % 3);
        last_due_b = (cycle + delay > last_due_b) ? cycle + delay : last_due_b + 1;
        due_b.push_back(last_due_b);
      end
      if (instr_idx < instr_list.size() && next_rand() % 8 != 0) begin
        instr_i       = instr_list[instr_idx];
        instr_valid_i = 1'b1;
      end else begin
        instr_valid_i = 1'b0;
      end
      // Result side stalls in bursts
      if (stall > 0) begin
        stall--;
        result_ready_i = 1'b0;
      end else begin
        result_ready_i = 1'b1;
        if (next_rand() % 16 == 0) begin
          stall = next_rand() % 8;
        end
      end
      #1;
      if (instr_valid_i && instr_ready_o) begin
        instr_idx++;
        pending++;
      end
      if (result_valid_o && result_ready_i) begin
        last_exp = exp_last.pop_front();
        check_word("result_o", result_o, exp_word.pop_front());
        check_last("result_last_o", result_last_o, last_exp);
        checked++;
        if (last_exp) begin
          pending--;
        end
        if (exp_pop_a.pop_front()) begin
          out_a--;
        end
        if (exp_pop_b.pop_front()) begin
          out_b--;
        end
      end
      if (cycle >= limit) begin
        $display("Timeout after %0d cycles, %0d result words never arrived",
                 cycle, exp_word.size());
        other_errs++;
        timed_out = 1'b1;
      end
    end
    $display("Summary: %0d words checked, %0d word errors, %0d flag errors, %0d other",
             checked, word_errs, flag_errs, other_errs);
    if (word_errs + flag_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_lane

`default_nettype wire

/* source/lane_operand_path.sv */
/* Instructions are taken only while instr_ready_o is high.
   Source words for a and b may arrive at any time once issued */
`timescale 1ns/10ps
`default_nettype none

module lane_operand_path import lane_pkg::*; #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned CmdDepth    = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Instruction input
  input  lane_instr_t instr_i,
  input  logic        instr_valid_i,
  output logic        instr_ready_o,
  // Operand a from the register file
  input  elen_t       opa_i,
  input  logic        opa_valid_i,
  input  logic        opa_issued_i,
  output logic        opa_ready_o,
  // Operand b from the register file
  input  elen_t       opb_i,
  input  logic        opb_valid_i,
  input  logic        opb_issued_i,
  output logic        opb_ready_o,
  // Results
  output elen_t       result_o,
  output logic        result_valid_o,
  output logic        result_last_o,
  input  logic        result_ready_i
);

  logic      instr_accept;
  logic      opq_a_full, opq_b_full, valu_full;
  opq_cmd_t  opq_a_cmd, opq_b_cmd;
  valu_cmd_t valu_cmd;
  elen_t     opa_word, opb_word;
  logic      opa_word_valid, opb_word_valid;
  logic      operand_ready;

  // All three commands go in together, so all FIFOs need room
  assign instr_ready_o = !(opq_a_full || opq_b_full || valu_full);
  assign instr_accept  = instr_valid_i && instr_ready_o;

  assign opq_a_cmd = '{conv: instr_i.conv_a, vew: instr_i.vew, vl: instr_i.vl};
  assign opq_b_cmd = '{conv: instr_i.conv_b, vew: instr_i.vew, vl: instr_i.vl};
  assign valu_cmd  = '{op: instr_i.op, vew: instr_i.vew, vl: instr_i.vl};

  operand_queue #(
    .BufferDepth(BufferDepth),
    .CmdDepth   (CmdDepth)
  ) u_opq_a (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmd_i                (opq_a_cmd),
    .cmd_valid_i          (instr_accept),
    .cmd_full_o           (opq_a_full),
    .operand_i            (opa_i),
    .operand_valid_i      (opa_valid_i),
    .operand_issued_i     (opa_issued_i),
    .operand_queue_ready_o(opa_ready_o),
    .operand_o            (opa_word),
    .operand_valid_o      (opa_word_valid),
    .operand_ready_i      (operand_ready)
  );

  operand_queue #(
    .BufferDepth(BufferDepth),
    .CmdDepth   (CmdDepth)
  ) u_opq_b (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cmd_i                (opq_b_cmd),
    .cmd_valid_i          (instr_accept),
    .cmd_full_o           (opq_b_full),
    .operand_i            (opb_i),
    .operand_valid_i      (opb_valid_i),
    .operand_issued_i     (opb_issued_i),
    .operand_queue_ready_o(opb_ready_o),
    .operand_o            (opb_word),
    .operand_valid_o      (opb_word_valid),
    .operand_ready_i      (operand_ready)
  );

  lane_valu #(
    .CmdDepth(CmdDepth)
  ) u_valu (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (valu_cmd),
    .cmd_valid_i    (instr_accept),
    .cmd_full_o     (valu_full),
    .opa_i          (opa_word),
    .opa_valid_i    (opa_word_valid),
    .opb_i          (opb_word),
    .opb_valid_i    (opb_word_valid),
    .operand_ready_o(operand_ready),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_last_o  (result_last_o),
    .result_ready_i (result_ready_i)
  );

endmodule : lane_operand_path

`default_nettype wire

/* source/lane_valu.sv */
/* Both operand words are consumed together, only when the result is taken.
   Operand streams must stay aligned with the buffered commands */
`timescale 1ns/10ps
`default_nettype none

module lane_valu import lane_pkg::*; #(
  parameter int unsigned CmdDepth = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Commands from the top level
  input  valu_cmd_t cmd_i,
  input  logic      cmd_valid_i,
  output logic      cmd_full_o,
  // Operand queues
  input  elen_t     opa_i,
  input  logic      opa_valid_i,
  input  elen_t     opb_i,
  input  logic      opb_valid_i,
  output logic      operand_ready_o,
  // Result stream
  output elen_t     result_o,
  output logic      result_valid_o,
  output logic      result_last_o,
  input  logic      result_ready_i
);

  valu_cmd_t cmd;
  logic      cmd_empty;
  logic      cmd_pop;

  lane_fifo #(
    .Width($bits(valu_cmd_t)),
    .Depth(CmdDepth)
  ) u_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .full_o (cmd_full_o),
    .empty_o(cmd_empty)
  );

  vlen_t cnt_d, cnt_q, cnt_next;
  logic  handshake;
  logic  last_word;

  assign result_valid_o  = opa_valid_i && opb_valid_i && !cmd_empty;
  assign handshake       = result_valid_o && result_ready_i;
  // Ready goes back to both queues, so they pop in lock step
  assign operand_ready_o = handshake;

  // Byte-sliced datapath, carry chain cut at element boundaries
  always_comb begin : p_alu
    logic [8:0] sum;
    logic [7:0] b_byte;
    logic       carry;
    carry = 1'b0;
    for (int k = 0; k < 8; k++) begin
      // Subtract as a plus inverted b plus one
      b_byte = (cmd.op == ValuSub) ? ~opb_i[8*k +: 8] : opb_i[8*k +: 8];
      if ((k & ((1 << cmd.vew) - 1)) == 0) begin
        carry = (cmd.op == ValuSub);
      end
      sum   = {1'b0, opa_i[8*k +: 8]} + {1'b0, b_byte} + {8'd0, carry};
      carry = sum[8];
      case (cmd.op)
        ValuAnd: result_o[8*k +: 8] = opa_i[8*k +: 8] & opb_i[8*k +: 8];
        ValuXor: result_o[8*k +: 8] = opa_i[8*k +: 8] ^ opb_i[8*k +: 8];
        default: result_o[8*k +: 8] = sum[7:0];
      endcase
    end
  end

  // Element count after this word
  assign cnt_next      = cnt_q + elems_per_word(cmd.vew);
  assign last_word     = (cnt_next >= cmd.vl);
  assign result_last_o = result_valid_o && last_word;
  assign cmd_pop       = handshake && last_word;

  always_comb begin : p_count
    cnt_d = cnt_q;
    if (handshake) begin
      cnt_d = last_word ? '0 : cnt_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule : lane_valu

`default_nettype wire

/* source/operand_queue.sv */
/* Source must only issue while operand_queue_ready_o is high.
   A conversion wider than the destination width allows is handled as no conversion */
`timescale 1ns/10ps
`default_nettype none

module operand_queue import lane_pkg::*; #(
  parameter int unsigned BufferDepth = 2,
  parameter int unsigned CmdDepth    = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Commands from the top level
  input  opq_cmd_t cmd_i,
  input  logic     cmd_valid_i,
  output logic     cmd_full_o,
  // Register file side
  input  elen_t    operand_i,
  input  logic     operand_valid_i,
  input  logic     operand_issued_i,
  output logic     operand_queue_ready_o,
  // Vector unit side
  output elen_t    operand_o,
  output logic     operand_valid_o,
  input  logic     operand_ready_i
);

  localparam int unsigned CreditWidth = $clog2(BufferDepth + 1);

  // Log2 of the widening factor
  function automatic logic [1:0] conv_shift(opq_conv_e conv);
    case (conv)
      OpqConvSExt2, OpqConvZExt2: return 2'd1;
      OpqConvSExt4, OpqConvZExt4: return 2'd2;
      OpqConvSExt8, OpqConvZExt8: return 2'd3;
      default:                    return 2'd0;
    endcase
  endfunction

  function automatic logic conv_signed(opq_conv_e conv);
    return (conv == OpqConvSExt2) || (conv == OpqConvSExt4) || (conv == OpqConvSExt8);
  endfunction

  opq_cmd_t cmd;
  logic     cmd_empty;
  logic     cmd_pop;

  lane_fifo #(
    .Width($bits(opq_cmd_t)),
    .Depth(CmdDepth)
  ) u_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .full_o (cmd_full_o),
    .empty_o(cmd_empty)
  );

  elen_t ibuf_word;
  logic  ibuf_empty;
  logic  ibuf_pop;

  // Credits keep this buffer from overflowing, so its full flag is not needed
  lane_fifo #(
    .Width($bits(elen_t)),
    .Depth(BufferDepth)
  ) u_data_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (ibuf_pop),
    .data_o (ibuf_word),
    .full_o (),
    .empty_o(ibuf_empty)
  );

  // Outstanding words: issued but not yet popped
  logic [CreditWidth-1:0] credit_d, credit_q;

  always_comb begin : p_credit
    credit_d = credit_q;
    if (operand_issued_i) begin
      credit_d = credit_d + 1'b1;
    end
    if (ibuf_pop) begin
      credit_d = credit_d - 1'b1;
    end
  end

  assign operand_queue_ready_o = (credit_q < CreditWidth'(BufferDepth));

  // Slice select within the head word, and delivered element count
  logic [2:0] sel_d, sel_q;
  logic [2:0] sel_last;
  vlen_t      cnt_d, cnt_q;
  logic [1:0] shift;
  logic [1:0] src_ew;
  logic       sext;
  elen_t      slice;
  elen_t      conv_word;

  always_comb begin : p_conv
    int unsigned dst_bytes;
    int unsigned src_bytes;
    int unsigned elem;
    int unsigned byte_in_elem;
    shift = conv_shift(cmd.conv);
    if (shift > cmd.vew) begin
      shift = 2'd0;
    end
    src_ew    = cmd.vew - shift;
    sext      = conv_signed(cmd.conv);
    sel_last  = 3'((4'd1 << shift) - 4'd1);
    // Each slice is 64/factor bits, the current one moved down to bit 0
    slice     = ibuf_word >> ({sel_q, 6'd0} >> shift);
    dst_bytes = 1 << cmd.vew;
    src_bytes = 1 << src_ew;
    // Built byte by byte, low bytes of each element come from the slice
    for (int k = 0; k < 8; k++) begin
      elem         = k >> cmd.vew;
      byte_in_elem = k & (dst_bytes - 1);
      if (byte_in_elem < src_bytes) begin
        conv_word[8*k +: 8] = slice[8*(elem*src_bytes + byte_in_elem) +: 8];
      end else begin
        // Fill from the top bit of the source element
        conv_word[8*k +: 8] = {8{sext & slice[8*(elem + 1)*src_bytes - 1]}};
      end
    end
  end

  assign operand_o       = conv_word;
  // Needs both a word and the command that explains it
  assign operand_valid_o = !ibuf_empty && !cmd_empty;

  always_comb begin : p_out_ctrl
    ibuf_pop = 1'b0;
    cmd_pop  = 1'b0;
    sel_d    = sel_q;
    cnt_d    = cnt_q;
    if (operand_valid_o && operand_ready_i) begin
      cnt_d = cnt_q + elems_per_word(cmd.vew);
      // Last slice used up, move on to the next input word
      if (sel_q == sel_last) begin
        ibuf_pop = 1'b1;
        sel_d    = '0;
      end else begin
        sel_d = sel_q + 3'd1;
      end
      // Instruction done, drop any partial input word too
      if (cnt_d >= cmd.vl) begin
        ibuf_pop = 1'b1;
        cmd_pop  = 1'b1;
        sel_d    = '0;
        cnt_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
      sel_q    <= '0;
      cnt_q    <= '0;
    end else begin
      credit_q <= credit_d;
      sel_q    <= sel_d;
      cnt_q    <= cnt_d;
    end
  end

endmodule : operand_queue

`default_nettype wire

/* source/lane_fifo.sv */
/* Any Depth from 1 up; data_o is undefined while empty.
   A push when full and a pop when empty are dropped */
`timescale 1ns/10ps
`default_nettype none

module lane_fifo #(
  parameter int unsigned Width = 64,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth  = $clog2(Depth + 1);

  logic [Width-1:0]     mem_q [Depth];
  logic [AddrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 do_push, do_pop;

  // Pointer wrap also covers depths that are not a power of two
  function automatic logic [AddrWidth-1:0] next_ptr(logic [AddrWidth-1:0] ptr);
    if (ptr == AddrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  // Head of queue, read straight from storage
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop keep the fill level
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule : lane_fifo

`default_nettype wire

/* source/lane_pkg.sv */
/* Shared types of the lane operand path. Widths are fixed to a 64-bit word
   and vl is counted in destination elements, up to 512 */
`default_nettype none

package lane_pkg;

  // One data word as read from the register file
  typedef logic [63:0] elen_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Widening conversion applied by an operand queue
  typedef enum logic [2:0] {
    OpqConvNone  = 3'd0,
    OpqConvSExt2 = 3'd1,
    OpqConvSExt4 = 3'd2,
    OpqConvSExt8 = 3'd3,
    OpqConvZExt2 = 3'd4,
    OpqConvZExt4 = 3'd5,
    OpqConvZExt8 = 3'd6
  } opq_conv_e;

  // Element-wise integer operations
  typedef enum logic [1:0] {
    ValuAdd = 2'd0,
    ValuSub = 2'd1,
    ValuAnd = 2'd2,
    ValuXor = 2'd3
  } valu_op_e;

  // Vector length in destination elements
  typedef logic [9:0] vlen_t;

  // Queue command, vew is the destination width
  typedef struct packed {
    opq_conv_e conv;
    vew_e      vew;
    vlen_t     vl;
  } opq_cmd_t;

  // Vector unit command
  typedef struct packed {
    valu_op_e op;
    vew_e     vew;
    vlen_t    vl;
  } valu_cmd_t;

  // Full instruction as seen at the top level
  typedef struct packed {
    valu_op_e  op;
    vew_e      vew;
    vlen_t     vl;
    opq_conv_e conv_a;
    opq_conv_e conv_b;
  } lane_instr_t;

  // Destination elements carried by one word: 8, 4, 2 or 1
  function automatic vlen_t elems_per_word(vew_e vew);
    return vlen_t'(8) >> vew;
  endfunction

endpackage : lane_pkg

`default_nettype wire
